//--- include/floor_pattern.svh
//////////////////////////////////////////////////
// Ground texture bitmap, four rows of 128 bits
//////////////////////////////////////////////////

`ifndef FLOOR_PATTERN_SVH
`define FLOOR_PATTERN_SVH

// Row 3 comes first so that index 0 of the packed result is row 0,
// the row drawn at the floor line. Bit n is texture column n
`define FLOOR_PATTERN { \
    128'h0080_2000_3604_0080_0004_0810_0400_0002, \
    128'h0000_0000_0000_0000_0000_03E0_0000_0000, \
    128'hFFFF_FFFF_FFFF_FFFF_FFFF_3E3F_FFFF_FFFF, \
    128'h0000_0000_0000_0000_0000_E000_0000_0000  \
}

`endif

//--- src/render_pkg.sv
//////////////////////////////////////////////////
// Renderer package
// Coordinate types, colour palette and sprite sizes
//////////////////////////////////////////////////

`default_nettype none

package render_pkg;

    // Screen pixel coordinate from the video timing source
    typedef logic [9:0] coord_t;

    // Scroll position, also the width of all scroll arithmetic
    typedef logic [10:0] scroll_t;

    // Goose jump height above its resting row
    typedef logic [6:0] jump_t;

    // 2 bits per channel, 6-bit colour
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    // Background layers
    localparam rgb_t SKY_RGB     = '{r: 2'b00, g: 2'b11, b: 2'b11};
    localparam rgb_t FLOOR_RGB   = '{r: 2'b01, g: 2'b01, b: 2'b01};
    localparam rgb_t TEXTURE_RGB = '{r: 2'b11, g: 2'b11, b: 2'b11};
    localparam rgb_t BLANK_RGB   = '0;

    // Goose parts
    localparam rgb_t BROWN_RGB   = '{r: 2'b10, g: 2'b10, b: 2'b01};
    localparam rgb_t BLACK_RGB   = '{r: 2'b00, g: 2'b00, b: 2'b00};
    localparam rgb_t ORANGE_RGB  = '{r: 2'b11, g: 2'b10, b: 2'b01};

    // Game-over tint for every goose part
    localparam rgb_t HIT_RGB     = '{r: 2'b11, g: 2'b00, b: 2'b00};

    // Shield field
    localparam rgb_t GOLD_RGB    = '{r: 2'b11, g: 2'b10, b: 2'b00};

    // Goose bounding box
    localparam int GOOSE_WIDTH  = 30;
    localparam int GOOSE_HEIGHT = 40;

    // Shield box, bottom edge sits on the floor line
    localparam int OBSTACLE_WIDTH  = 40;
    localparam int OBSTACLE_HEIGHT = 48;

    // Ground texture bitmap size
    localparam int TEXTURE_ROWS   = 4;
    localparam int TEXTURE_LENGTH = 128;

endpackage

`default_nettype wire

//--- src/goose_sprite.sv
//////////////////////////////////////////////////
// Goose sprite generator
// Registered hit flag and part colour per pixel
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module goose_sprite #(
    parameter int FLOOR_Y      = 240,
    parameter int GOOSE_X      = 50,
    parameter int GOOSE_Y_BASE = 200
) (
    input  wire                     clk,
    input  wire                     sys_rst,
    input  wire render_pkg::coord_t haddr,
    input  wire render_pkg::coord_t vaddr,
    input  wire render_pkg::jump_t  jump_pos,
    input  wire                     display_on,
    input  wire                     game_start_blink,
    input  wire                     game_over,
    output logic                    goose_hit,
    output render_pkg::rgb_t        goose_rgb
);

    import render_pkg::*;

    logic [10:0] goose_y;
    logic [10:0] row_off;
    logic [10:0] col_off;
    logic        in_box;
    logic        part_hit;
    rgb_t        part_rgb;

    // Top row moves up by the jump height
    assign goose_y = 11'(GOOSE_Y_BASE) - {4'd0, jump_pos};

    // Offsets wrap to large values left of or above the box
    assign row_off = {1'b0, vaddr} - goose_y;
    assign col_off = {1'b0, haddr} - 11'(GOOSE_X);

    // Clipped at the floor line
    assign in_box = (row_off < GOOSE_HEIGHT) && (col_off < GOOSE_WIDTH) &&
                    (vaddr < FLOOR_Y);

    // First matching part sets the hit
    always_comb begin
        part_hit = 1'b0;
        part_rgb = BLACK_RGB;
        if (in_box && game_start_blink) begin
            if (row_off >= 20 && row_off <= 35 && col_off >= 5 && col_off <= 25) begin
                // Body
                part_hit = 1'b1;
                part_rgb = BROWN_RGB;
            end else if (row_off >= 10 && row_off <= 19 &&
                         col_off >= 18 && col_off <= 22) begin
                // Neck
                part_hit = 1'b1;
                part_rgb = BLACK_RGB;
            end else if (row_off >= 5 && row_off <= 9 &&
                         col_off >= 18 && col_off <= 26) begin
                // Head wins column 26 over the beak
                part_hit = 1'b1;
                part_rgb = BLACK_RGB;
            end else if (row_off >= 7 && row_off <= 9 &&
                         col_off >= 26 && col_off <= 29) begin
                // Beak
                part_hit = 1'b1;
                part_rgb = ORANGE_RGB;
            end else if (row_off >= 36 && row_off <= 39 &&
                         ((col_off >= 10 && col_off <= 12) ||
                          (col_off >= 18 && col_off <= 20))) begin
                // Two legs
                part_hit = 1'b1;
                part_rgb = BLACK_RGB;
            end
        end
        // Whole goose turns red once the game is lost
        if (part_hit && game_over) begin
            part_rgb = HIT_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            goose_hit <= 1'b0;
        end else begin
            goose_hit <= display_on && part_hit;
        end
    end

    // Part colour registered alongside the hit flag
    always_ff @(posedge clk) begin
        goose_rgb <= part_rgb;
    end

endmodule

`default_nettype wire

//--- src/obstacle_sprite.sv
//////////////////////////////////////////////////
// Obstacle sprite generator
// Scrolling gold shield with a black outline
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module obstacle_sprite #(
    parameter int FLOOR_Y        = 240,
    parameter int OBSTACLE_START = 890
) (
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire render_pkg::coord_t  haddr,
    input  wire render_pkg::coord_t  vaddr,
    input  wire render_pkg::scroll_t scrolladdr,
    input  wire                      display_on,
    input  wire                      obstacle_active,
    output logic                     obstacle_hit,
    output render_pkg::rgb_t         obstacle_rgb
);

    import render_pkg::*;

    scroll_t left_col;
    scroll_t col_off;
    scroll_t row_off;
    logic    in_shield;
    logic    on_outline;

    // Shield moves left as the scroll position grows
    assign left_col = scroll_t'(OBSTACLE_START) - scrolladdr;

    // Local coordinates, wrapping outside the box
    assign col_off = {1'b0, haddr} - left_col;
    assign row_off = {1'b0, vaddr} - scroll_t'(FLOOR_Y - OBSTACLE_HEIGHT);

    assign in_shield = obstacle_active &&
                       (col_off < OBSTACLE_WIDTH) && (row_off < OBSTACLE_HEIGHT);

    // Two rows on top, one column each side
    assign on_outline = (row_off < 2) || (col_off == 0) ||
                        (col_off == scroll_t'(OBSTACLE_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            obstacle_hit <= 1'b0;
        end else begin
            obstacle_hit <= display_on && in_shield;
        end
    end

    always_ff @(posedge clk) begin
        obstacle_rgb <= on_outline ? BLACK_RGB : GOLD_RGB;
    end

endmodule

`default_nettype wire

//--- src/floor_layer.sv
//////////////////////////////////////////////////
// Background layer generator
// Sky and ground bands, scrolling floor texture
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "floor_pattern.svh"

module floor_layer #(
    parameter int FLOOR_Y = 240
) (
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire render_pkg::coord_t  haddr,
    input  wire render_pkg::coord_t  vaddr,
    input  wire render_pkg::scroll_t scrolladdr,
    input  wire                      display_on,
    output logic                     sky_hit,
    output logic                     ground_hit,
    output logic                     texture_hit
);

    import render_pkg::*;

    localparam int ROW_BITS = $clog2(TEXTURE_ROWS);
    localparam int IDX_BITS = $clog2(TEXTURE_LENGTH);

    localparam logic [TEXTURE_ROWS-1:0][TEXTURE_LENGTH-1:0] FLOOR_BITS = `FLOOR_PATTERN;

    scroll_t             row_off;
    logic [IDX_BITS-1:0] tex_idx;
    logic                tex_bit;

    assign row_off = {1'b0, vaddr} - scroll_t'(FLOOR_Y);

    // Pattern repeats every 128 columns
    assign tex_idx = haddr[IDX_BITS-1:0] + scrolladdr[IDX_BITS-1:0];

    // Only the top rows of the ground carry texture
    assign tex_bit = (row_off < TEXTURE_ROWS) && FLOOR_BITS[row_off[ROW_BITS-1:0]][tex_idx];

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            sky_hit     <= 1'b0;
            ground_hit  <= 1'b0;
            texture_hit <= 1'b0;
        end else begin
            sky_hit     <= display_on && (vaddr < FLOOR_Y);
            ground_hit  <= display_on && (vaddr >= FLOOR_Y);
            texture_hit <= display_on && tex_bit;
        end
    end

endmodule

`default_nettype wire

//--- src/layer_compositor.sv
//////////////////////////////////////////////////
// Layer compositor
// Priority colour select, blanking and collision
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module layer_compositor (
    input  wire                   goose_hit,
    input  wire render_pkg::rgb_t goose_rgb,
    input  wire                   obstacle_hit,
    input  wire render_pkg::rgb_t obstacle_rgb,
    input  wire                   sky_hit,
    input  wire                   ground_hit,
    input  wire                   texture_hit,
    input  wire                   display_on,
    output logic [1:0]            R,
    output logic [1:0]            G,
    output logic [1:0]            B,
    output logic                  collision
);

    import render_pkg::*;

    rgb_t layer_rgb;
    rgb_t pixel_rgb;

    // Goose on top, sky at the back
    always_comb begin
        if (goose_hit) begin
            layer_rgb = goose_rgb;
        end else if (obstacle_hit) begin
            layer_rgb = obstacle_rgb;
        end else if (texture_hit) begin
            layer_rgb = TEXTURE_RGB;
        end else if (ground_hit) begin
            layer_rgb = FLOOR_RGB;
        end else if (sky_hit) begin
            layer_rgb = SKY_RGB;
        end else begin
            layer_rgb = BLANK_RGB;
        end
    end

    // Live display_on, so blanking takes effect in the same cycle
    assign pixel_rgb = display_on ? layer_rgb : BLANK_RGB;

    assign R = pixel_rgb.r;
    assign G = pixel_rgb.g;
    assign B = pixel_rgb.b;

    assign collision = goose_hit & obstacle_hit;

endmodule

`default_nettype wire

//--- src/render_top.sv
//////////////////////////////////////////////////
// Scanline renderer top level
// Sprite and layer generators into the compositor
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module render_top #(
    parameter int FLOOR_Y        = 240,
    parameter int GOOSE_X        = 50,
    parameter int GOOSE_Y_BASE   = 200,
    parameter int OBSTACLE_START = 890
) (
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire render_pkg::coord_t  haddr,
    input  wire render_pkg::coord_t  vaddr,
    input  wire render_pkg::scroll_t scrolladdr,
    input  wire render_pkg::jump_t   jump_pos,
    input  wire                      display_on,
    input  wire                      game_over,
    input  wire                      game_start_blink,
    input  wire                      obstacle_active,
    output wire [1:0]                R,
    output wire [1:0]                G,
    output wire [1:0]                B,
    output wire                      collision
);

    import render_pkg::*;

    // Generator outputs, one cycle behind the pixel address
    logic goose_hit;
    rgb_t goose_rgb;
    logic obstacle_hit;
    rgb_t obstacle_rgb;
    logic sky_hit;
    logic ground_hit;
    logic texture_hit;

    goose_sprite #(
        .FLOOR_Y      (FLOOR_Y),
        .GOOSE_X      (GOOSE_X),
        .GOOSE_Y_BASE (GOOSE_Y_BASE)
    ) goose_sprite_inst (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .jump_pos         (jump_pos),
        .display_on       (display_on),
        .game_start_blink (game_start_blink),
        .game_over        (game_over),
        .goose_hit        (goose_hit),
        .goose_rgb        (goose_rgb)
    );

    obstacle_sprite #(
        .FLOOR_Y        (FLOOR_Y),
        .OBSTACLE_START (OBSTACLE_START)
    ) obstacle_sprite_inst (
        .clk             (clk),
        .sys_rst         (sys_rst),
        .haddr           (haddr),
        .vaddr           (vaddr),
        .scrolladdr      (scrolladdr),
        .display_on      (display_on),
        .obstacle_active (obstacle_active),
        .obstacle_hit    (obstacle_hit),
        .obstacle_rgb    (obstacle_rgb)
    );

    floor_layer #(
        .FLOOR_Y (FLOOR_Y)
    ) floor_layer_inst (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .haddr       (haddr),
        .vaddr       (vaddr),
        .scrolladdr  (scrolladdr),
        .display_on  (display_on),
        .sky_hit     (sky_hit),
        .ground_hit  (ground_hit),
        .texture_hit (texture_hit)
    );

    // Combinational, blanks on the live display_on
    layer_compositor layer_compositor_inst (
        .goose_hit    (goose_hit),
        .goose_rgb    (goose_rgb),
        .obstacle_hit (obstacle_hit),
        .obstacle_rgb (obstacle_rgb),
        .sky_hit      (sky_hit),
        .ground_hit   (ground_hit),
        .texture_hit  (texture_hit),
        .display_on   (display_on),
        .R            (R),
        .G            (G),
        .B            (B),
        .collision    (collision)
    );

endmodule

`default_nettype wire

//--- verif/render_asserts.sv
//////////////////////////////////////////////////
// Renderer port assertions
// Blanking, collision source and reset behaviour
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module render_asserts (
    input wire       clk,
    input wire       sys_rst,
    input wire       display_on,
    input wire       game_start_blink,
    input wire       obstacle_active,
    input wire [1:0] R,
    input wire [1:0] G,
    input wire [1:0] B,
    input wire       collision
);

    int assert_failures = 0;

    // No colour while the display is off
    blank_when_off: assert property (
        @(posedge clk) disable iff (sys_rst) !display_on |-> ({R, G, B} == 6'd0)
    ) else begin
        assert_failures++;
        $error("Colour outputs not zero while display_on is low");
    end

    // Both sprites enabled for the pixel one cycle back
    collision_source: assert property (
        @(posedge clk) disable iff (sys_rst)
        collision |-> $past(obstacle_active && game_start_blink)
    ) else begin
        assert_failures++;
        $error("Collision without obstacle and goose enabled one cycle earlier");
    end

    // Hit flags leave reset cleared
    clear_after_reset: assert property (
        @(posedge clk) $past(sys_rst) |-> !collision
    ) else begin
        assert_failures++;
        $error("Collision high in the cycle after reset");
    end

endmodule

`default_nettype wire

//--- verif/render_tb.sv
//////////////////////////////////////////////////
// Renderer testbench
// Directed pixel probes on the renderer top level
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "floor_pattern.svh"

module render_tb;

    import render_pkg::*;

    // Same values as the render_top defaults
    localparam int FLOOR_Y        = 240;
    localparam int GOOSE_X        = 50;
    localparam int GOOSE_Y_BASE   = 200;
    localparam int OBSTACLE_START = 890;

    localparam int CLK_PERIOD = 20;
    localparam int TEST_STEPS = 88;
    localparam int TIMEOUT_NS = TEST_STEPS * 2 * CLK_PERIOD + 10 * CLK_PERIOD + 1000;

    localparam logic [TEXTURE_ROWS-1:0][TEXTURE_LENGTH-1:0] FLOOR_BITS = `FLOOR_PATTERN;

    logic      clk;
    logic      sys_rst;
    coord_t    haddr;
    coord_t    vaddr;
    scroll_t   scrolladdr;
    jump_t     jump_pos;
    logic      display_on;
    logic      game_over;
    logic      game_start_blink;
    logic      obstacle_active;
    wire [1:0] R;
    wire [1:0] G;
    wire [1:0] B;
    wire       collision;

    render_top render_top_inst (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .display_on       (display_on),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .obstacle_active  (obstacle_active),
        .R                (R),
        .G                (G),
        .B                (B),
        .collision        (collision)
    );

    bind render_top render_asserts render_asserts_inst (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .display_on       (display_on),
        .game_start_blink (game_start_blink),
        .obstacle_active  (obstacle_active),
        .R                (R),
        .G                (G),
        .B                (B),
        .collision        (collision)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_rgb(input rgb_t expected, input string what);
        rgb_t actual;
        actual = rgb_t'({R, G, B});
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, expected rgb %b, got %b",
                     $time, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_collision(input logic expected, input string what);
        if (collision !== expected) begin
            $display("MISMATCH at %0t ns: %s, expected collision %b, got %b",
                     $time, what, expected, collision);
            abort_run();
        end
    endtask

    // Inputs change 2 ns after an edge and the result is read 1 ns after the next one
    task automatic drive_pixel(input int h, input int v, input int scroll, input int jump,
                               input logic blink, input logic over, input logic active);
        @(posedge clk);
        #2;
        haddr            = coord_t'(h);
        vaddr            = coord_t'(v);
        scrolladdr       = scroll_t'(scroll);
        jump_pos         = jump_t'(jump);
        game_start_blink = blink;
        game_over        = over;
        obstacle_active  = active;
        @(posedge clk);
        #1;
    endtask

    task automatic test_background();
        int h;
        h = $urandom_range(639);
        drive_pixel(h, 100, 0, 0, 1'b0, 1'b0, 1'b0);
        check_rgb(SKY_RGB, "sky pixel");
        drive_pixel(h, FLOOR_Y + 10, 0, 0, 1'b0, 1'b0, 1'b0);
        check_rgb(FLOOR_RGB, "ground pixel");
        // Blanking acts on the live display_on
        #1;
        display_on = 1'b0;
        #1;
        check_rgb(BLANK_RGB, "display_on dropped");
        // Flags cleared at a blanked edge stay clear
        drive_pixel(h, 100, 0, 0, 1'b0, 1'b0, 1'b0);
        #1;
        display_on = 1'b1;
        #1;
        check_rgb(BLANK_RGB, "pixel sampled with display_on low");
    endtask

    task automatic test_texture();
        int   scrolls [3] = '{0, 37, 1500};
        int   h;
        int   idx;
        rgb_t expected;
        foreach (scrolls[s]) begin
            for (int row = 0; row < TEXTURE_ROWS; row++) begin
                repeat (2) begin
                    h = $urandom_range(639);
                    drive_pixel(h, FLOOR_Y + row, scrolls[s], 0, 1'b0, 1'b0, 1'b0);
                    // Texture column wraps every 128 pixels
                    idx = (h + scrolls[s]) % TEXTURE_LENGTH;
                    expected = FLOOR_BITS[row][idx] ? TEXTURE_RGB : FLOOR_RGB;
                    check_rgb(expected, $sformatf("texture row %0d column %0d scroll %0d",
                                                  row, h, scrolls[s]));
                end
            end
        end
    endtask

    task automatic test_goose();
        // Probe points in goose-local rows and columns
        int    rows [7]  = '{25, 15, 6, 8, 8, 37, 37};
        int    cols [7]  = '{10, 20, 20, 28, 26, 11, 15};
        rgb_t  part [7]  = '{BROWN_RGB, BLACK_RGB, BLACK_RGB, ORANGE_RGB, BLACK_RGB,
                             BLACK_RGB, SKY_RGB};
        string names [7] = '{"body", "neck", "head", "beak", "head over beak", "leg",
                             "leg gap"};
        int    jumps [2] = '{0, 30};
        rgb_t  expected;
        // Mode 0 is normal play, 1 is game over and 2 is blink off
        for (int mode = 0; mode < 3; mode++) begin
            foreach (jumps[j]) begin
                foreach (rows[p]) begin
                    drive_pixel(GOOSE_X + cols[p], GOOSE_Y_BASE - jumps[j] + rows[p], 0,
                                jumps[j], mode != 2, mode == 1, 1'b0);
                    if (mode == 2 || part[p] == SKY_RGB) begin
                        expected = SKY_RGB;
                    end else if (mode == 1) begin
                        expected = HIT_RGB;
                    end else begin
                        expected = part[p];
                    end
                    check_rgb(expected, $sformatf("goose %s jump %0d mode %0d",
                                                  names[p], jumps[j], mode));
                end
            end
        end
    endtask

    task automatic test_obstacle();
        int   dx [6]     = '{10, 10, 20, 39, 0, 38};
        int   dy [6]     = '{0, 1, 20, 20, 30, 47};
        rgb_t shield [6] = '{BLACK_RGB, BLACK_RGB, GOLD_RGB, BLACK_RGB, BLACK_RGB, GOLD_RGB};
        int   left;
        int   top;
        left = OBSTACLE_START - 600;
        top  = FLOOR_Y - OBSTACLE_HEIGHT;
        for (int active = 1; active >= 0; active--) begin
            foreach (dx[p]) begin
                drive_pixel(left + dx[p], top + dy[p], 600, 0, 1'b0, 1'b0, active[0]);
                check_rgb(active ? shield[p] : SKY_RGB,
                          $sformatf("shield local %0d,%0d active %0d", dx[p], dy[p], active));
            end
        end
        // Shield at column 55 now runs under the goose body
        drive_pixel(GOOSE_X + 10, GOOSE_Y_BASE + 25, 835, 0, 1'b1, 1'b0, 1'b1);
        check_rgb(BROWN_RGB, "goose drawn over shield");
        drive_pixel(90, GOOSE_Y_BASE + 25, 835, 0, 1'b1, 1'b0, 1'b1);
        check_rgb(GOLD_RGB, "shield beside goose");
    endtask

    task automatic test_collision();
        drive_pixel(60, 225, 835, 0, 1'b1, 1'b0, 1'b1);
        check_collision(1'b1, "goose over shield");
        drive_pixel(60, 225, 835, 0, 1'b1, 1'b1, 1'b1);
        check_collision(1'b1, "goose over shield after game over");
        check_rgb(HIT_RGB, "red goose over shield");
        drive_pixel(60, 225, 835, 0, 1'b1, 1'b0, 1'b0);
        check_collision(1'b0, "shield switched off");
        drive_pixel(60, 225, 835, 0, 1'b0, 1'b0, 1'b1);
        check_collision(1'b0, "goose blinked off");
        drive_pixel(90, 225, 835, 0, 1'b1, 1'b0, 1'b1);
        check_collision(1'b0, "shield without goose");
    endtask

    initial begin
        void'($urandom(67612));
        // Reset holds against a colliding pixel with the display on
        sys_rst          = 1'b1;
        haddr            = coord_t'(60);
        vaddr            = coord_t'(225);
        scrolladdr       = scroll_t'(835);
        jump_pos         = '0;
        display_on       = 1'b1;
        game_over        = 1'b0;
        game_start_blink = 1'b1;
        obstacle_active  = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_collision(1'b0, "collision held in reset");
        check_rgb(BLANK_RGB, "colour held in reset");
        #1;
        sys_rst          = 1'b0;
        game_start_blink = 1'b0;
        obstacle_active  = 1'b0;
        test_background();
        test_texture();
        test_goose();
        test_obstacle();
        test_collision();
        if (render_top_inst.render_asserts_inst.assert_failures == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Assertion failures: %0d",
                     render_top_inst.render_asserts_inst.assert_failures);
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        abort_run();
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/render_pkg.sv
src/goose_sprite.sv
src/obstacle_sprite.sv
src/floor_layer.sv
src/layer_compositor.sv
src/render_top.sv
verif/render_asserts.sv
verif/render_tb.sv
